/* video_to_ram.f */
video_ram_pkg.sv
line_capture.sv
line_store.sv
burst_writer.sv
word_formatter.sv
video_to_ram.sv
tb_video_to_ram.sv

/* Makefile */
# Verilator build, run and lint for the video line to memory writer

VERILATOR ?= verilator
TOP       ?= tb_video_to_ram
FILELIST  ?= video_to_ram.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || \
		(echo "Simulation ended without a result, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_video_to_ram.sv */
/*
 * Testbench for the video line to memory writer. Sends three random lines,
 * answers bursts with a memory slave model and checks every address and word.
 */
module tb_video_to_ram
	import video_ram_pkg::*;
();

	////////////////////////////////////////////////////////////////////////////
	// Parameters
	////////////////////////////////////////////////////////////////////////////

	localparam int        BURST_LEN       = 4;
	localparam int        PIXELS_PER_LINE = 16;
	localparam int        PIXEL_OFFSET    = 2;
	localparam bus_addr_t RAM_BASE_ADDR   = 32'h1000;
	localparam int        BYTES_PER_LINE  = 256;

	localparam int        NUM_LINES       = 3;
	localparam int        PIX_TOTAL       = PIXEL_OFFSET + PIXELS_PER_LINE;	// Sent per line
	localparam int        BURSTS_PER_LINE = PIXELS_PER_LINE / BURST_LEN;
	localparam int        TOTAL_BURSTS    = NUM_LINES * BURSTS_PER_LINE;
	localparam line_num_t FIRST_LINE      = 10'd37;
	localparam int        INIT_HOLD       = 30;	// Cycles of pending init after line 0
	localparam int        TIMEOUT_CYCLES  = NUM_LINES * PIXELS_PER_LINE * 40 + 2000;

	// DUT ports
	logic      i_clk_100_bus = 1'b0;
	logic      i_sys_rst;
	logic      i_pix_valid;
	pixel_t    i_pixel;
	logic      i_new_line;
	line_num_t i_line_num;
	logic      i_mem_init_done;
	logic      i_bus_addr_ack;
	logic      i_bus_wr_comp;
	logic      o_bus_request;
	bus_addr_t o_bus_addr;
	logic      o_bus_wr_burst;
	bus_word_t o_bus_wr_data;
	logic      o_bus_wr_valid;

	// Stimulus record and scoreboard state
	integer    seed = 32'hbe4c;
	pixel_t    line_pix [NUM_LINES][PIX_TOTAL];
	line_num_t line_nums [NUM_LINES];
	int        ack_waits [TOTAL_BURSTS];	// Slave delay per burst
	int        errors = 0;
	int        checks = 0;
	int        grants = 0;	// Bursts acknowledged so far
	int        words = 0;	// Valid beats seen
	int        beat_in_burst = 0;
	int        comp_count = 0;	// Completions from the slave
	logic      rst_seen = 1'b0;

	always #10 i_clk_100_bus = ~i_clk_100_bus;	// Period 20

	video_to_ram #(
		.BURST_LEN       (BURST_LEN),
		.PIXELS_PER_LINE (PIXELS_PER_LINE),
		.PIXEL_OFFSET    (PIXEL_OFFSET),
		.RAM_BASE_ADDR   (RAM_BASE_ADDR),
		.BYTES_PER_LINE  (BYTES_PER_LINE)
	) uut (
		.i_clk_100_bus   (i_clk_100_bus),
		.i_sys_rst       (i_sys_rst),
		.i_pix_valid     (i_pix_valid),
		.i_pixel         (i_pixel),
		.i_new_line      (i_new_line),
		.i_line_num      (i_line_num),
		.i_mem_init_done (i_mem_init_done),
		.i_bus_addr_ack  (i_bus_addr_ack),
		.i_bus_wr_comp   (i_bus_wr_comp),
		.o_bus_request   (o_bus_request),
		.o_bus_addr      (o_bus_addr),
		.o_bus_wr_burst  (o_bus_wr_burst),
		.o_bus_wr_data   (o_bus_wr_data),
		.o_bus_wr_valid  (o_bus_wr_valid)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// Word k of a line, top 6 bits of each colour left in its own byte
	function automatic bus_word_t packed_word(input int line_idx, input int k);
		pixel_t     px;
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
		px    = line_pix[line_idx][PIXEL_OFFSET + k];	// Skip the left edge
		red   = px[23:16] & 8'hfc;
		green = px[15:8] & 8'hfc;
		blue  = px[7:0] & 8'hfc;
		packed_word = {8'h00, red, green, blue};
	endfunction

	// Base, plus line stride, plus one burst of words per step
	function automatic bus_addr_t burst_address(input line_num_t num, input int burst);
		burst_address = RAM_BASE_ADDR + bus_addr_t'(num) * bus_addr_t'(BYTES_PER_LINE)
			+ bus_addr_t'(burst * BURST_LEN * BUS_BYTES_PER_WORD);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////////////////////////////////////////

	// One line of pixels with random idle gaps
	task automatic drive_line_pixels(input int idx);
		int p;
		p = 0;
		while (p < PIX_TOTAL)
		begin
			@(posedge i_clk_100_bus);
			#1;
			if (({$random(seed)} % 4) == 0)
				i_pix_valid = 1'b0;	// Source stalls
			else
			begin
				i_pix_valid = 1'b1;
				i_pixel     = line_pix[idx][p];
				p++;
			end
		end
		@(posedge i_clk_100_bus);
		#1 i_pix_valid = 1'b0;
	endtask

	// Single cycle new line pulse, number of the line just sent
	task automatic mark_new_line(input line_num_t num);
		@(posedge i_clk_100_bus);
		#1;
		i_new_line = 1'b1;
		i_line_num = num;
		@(posedge i_clk_100_bus);
		#1 i_new_line = 1'b0;
	endtask

	// Until n lines have had all their bursts completed
	task automatic wait_lines_done(input int n);
		do
			@(posedge i_clk_100_bus);
		while (comp_count < n * BURSTS_PER_LINE);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin : stimulus
		int k;
		int p;
		int end_errors;
		end_errors      = 0;
		i_sys_rst       = 1'b1;
		i_pix_valid     = 1'b0;
		i_pixel         = '0;
		i_new_line      = 1'b0;
		i_line_num      = '0;
		i_mem_init_done = 1'b0;	// Memory still initialising
		for (k = 0; k < NUM_LINES; k++)
		begin
			line_nums[k] = FIRST_LINE + line_num_t'(k);
			for (p = 0; p < PIX_TOTAL; p++)
				line_pix[k][p] = pixel_t'($random(seed));
		end
		for (k = 0; k < TOTAL_BURSTS; k++)
			ack_waits[k] = {$random(seed)} % 4;	// 0 to 3 cycles
		repeat (5) @(posedge i_clk_100_bus);
		#1 i_sys_rst = 1'b0;

		// Line 0 arrives while init is pending, no request allowed yet
		drive_line_pixels(0);
		mark_new_line(line_nums[0]);
		repeat (INIT_HOLD) @(posedge i_clk_100_bus);
		#1 i_mem_init_done = 1'b1;

		// Next line fills the other bank while the previous one drains
		for (k = 1; k < NUM_LINES; k++)
		begin
			drive_line_pixels(k);
			wait_lines_done(k);
			mark_new_line(line_nums[k]);
		end
		wait_lines_done(NUM_LINES);
		repeat (40) @(posedge i_clk_100_bus);	// Quiet bus after the last line

		if (grants != TOTAL_BURSTS || words != NUM_LINES * PIXELS_PER_LINE)
		begin
			end_errors++;
			$display("ERROR: expected %0d bursts and %0d words but saw %0d bursts and %0d words",
				TOTAL_BURSTS, NUM_LINES * PIXELS_PER_LINE, grants, words);
		end
		$display("Summary: %0d checks, %0d errors, %0d bursts, %0d words",
			checks, errors + end_errors, grants, words);
		if (errors + end_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Memory slave model
	////////////////////////////////////////////////////////////////////////////

	initial
	begin : memory_slave
		int ack_wait;
		int beats;
		i_bus_addr_ack = 1'b0;
		i_bus_wr_comp  = 1'b0;
		forever
		begin
			@(posedge i_clk_100_bus);
			if (o_bus_request && !i_sys_rst)
			begin
				ack_wait = (comp_count < TOTAL_BURSTS) ? ack_waits[comp_count] : 0;
				repeat (ack_wait) @(posedge i_clk_100_bus);	// Hold off the grant
				#1 i_bus_addr_ack = 1'b1;
				@(posedge i_clk_100_bus);
				#1 i_bus_addr_ack = 1'b0;
				beats = 0;
				while (beats < BURST_LEN)
				begin
					@(posedge i_clk_100_bus);
					if (o_bus_wr_valid)
						beats++;
				end
				#1 i_bus_wr_comp = 1'b1;	// Whole burst taken
				@(posedge i_clk_100_bus);
				#1 i_bus_wr_comp = 1'b0;
				comp_count++;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Comparison
	////////////////////////////////////////////////////////////////////////////

	always @(posedge i_clk_100_bus)
	begin : compare
		int        line_idx;
		int        word_idx;
		bus_addr_t exp_addr;
		bus_word_t exp_word;
		if (i_sys_rst)
		begin
			// Quiet bus once a reset edge has passed
			if (rst_seen)
			begin
				checks++;
				if (o_bus_request !== 1'b0 || o_bus_wr_burst !== 1'b0 || o_bus_wr_valid !== 1'b0)
				begin
					errors++;
					$display("FAILED reset outputs: o_bus_request %h o_bus_wr_burst %h o_bus_wr_valid %h, expected 0",
						o_bus_request, o_bus_wr_burst, o_bus_wr_valid);
				end
			end
			rst_seen = 1'b1;
		end
		else
		begin
			if (o_bus_request && !i_mem_init_done)
			begin
				errors++;
				$display("ERROR: bus request raised while memory init is pending at %0t", $time);
			end
			if (o_bus_request && !o_bus_wr_burst)
			begin
				errors++;
				$display("FAILED o_bus_wr_burst during request: got %h, expected 1", o_bus_wr_burst);
			end
			if (o_bus_request && grants >= TOTAL_BURSTS)
			begin
				errors++;
				$display("ERROR: bus request after the final line at %0t", $time);
			end
			else if (o_bus_request && i_bus_addr_ack)
			begin
				if (grants > 0 && beat_in_burst != BURST_LEN)
				begin
					errors++;
					$display("ERROR: burst %0d carried %0d valid beats instead of %0d",
						grants - 1, beat_in_burst, BURST_LEN);
				end
				line_idx = grants / BURSTS_PER_LINE;
				exp_addr = burst_address(line_nums[line_idx], grants % BURSTS_PER_LINE);
				checks++;
				if (o_bus_addr !== exp_addr)
				begin
					errors++;
					$display("FAILED o_bus_addr line %0d burst %0d: got %h, expected %h",
						line_idx, grants % BURSTS_PER_LINE, o_bus_addr, exp_addr);
				end
				grants++;
				beat_in_burst = 0;
			end
			if (o_bus_wr_valid)
			begin
				if (grants == 0 || beat_in_burst >= BURST_LEN)
				begin
					errors++;
					$display("ERROR: valid beat outside a granted burst at %0t", $time);
				end
				else
				begin
					line_idx = (grants - 1) / BURSTS_PER_LINE;
					word_idx = ((grants - 1) % BURSTS_PER_LINE) * BURST_LEN + beat_in_burst;
					exp_word = packed_word(line_idx, word_idx);
					checks++;
					if (o_bus_wr_data !== exp_word)
					begin
						errors++;
						$display("FAILED o_bus_wr_data line %0d word %0d: got %h, expected %h",
							line_idx, word_idx, o_bus_wr_data, exp_word);
					end
					if (!o_bus_wr_burst)
					begin
						errors++;
						$display("FAILED o_bus_wr_burst on valid beat: got %h, expected 1",
							o_bus_wr_burst);
					end
				end
				beat_in_burst++;
				words++;
			end
		end
	end

	// Hard stop if the bus hangs
	initial
	begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge i_clk_100_bus);
		$display("ERROR: timeout after %0d cycles, the line transfers did not finish",
			TIMEOUT_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* video_to_ram.sv */
/*
 * Video line to memory writer, top level. Captures lines into ping-pong
 * buffers and writes each finished line to memory in fixed bus bursts.
 */
module video_to_ram
	import video_ram_pkg::*;
#(
	parameter int        BURST_LEN       = 16,
	parameter int        PIXELS_PER_LINE = 720,
	parameter int        PIXEL_OFFSET    = 10,	// Aligns the frame horizontally
	parameter bus_addr_t RAM_BASE_ADDR   = '0,
	parameter int        BYTES_PER_LINE  = 4096
)
(
	input  logic      i_clk_100_bus,
	input  logic      i_sys_rst,

	// Video source
	input  logic      i_pix_valid,
	input  pixel_t    i_pixel,
	input  logic      i_new_line,
	input  line_num_t i_line_num,

	// Bus master
	input  logic      i_mem_init_done,
	input  logic      i_bus_addr_ack,
	input  logic      i_bus_wr_comp,
	output logic      o_bus_request,
	output bus_addr_t o_bus_addr,
	output logic      o_bus_wr_burst,
	output bus_word_t o_bus_wr_data,
	output logic      o_bus_wr_valid
);

	logic       w_wr_en;
	line_addr_t w_wr_addr;
	pixel_t     w_wr_pixel;
	logic       w_wr_bank;
	logic       w_line_ready;
	line_num_t  w_line_num;
	logic       w_line_done;
	logic       w_line_start;
	logic       w_beat;
	logic       w_rd_bank;
	line_addr_t w_rd_addr;
	pixel_t     w_rd_pixel;

	////////////////////////////////////////////////////////////////////////////
	// Capture and buffering
	////////////////////////////////////////////////////////////////////////////

	line_capture u_capture
	(
		.i_clk_100_bus (i_clk_100_bus),
		.i_sys_rst     (i_sys_rst),
		.i_pix_valid   (i_pix_valid),
		.i_pixel       (i_pixel),
		.i_new_line    (i_new_line),
		.i_line_num    (i_line_num),
		.i_line_done   (w_line_done),
		.o_wr_en       (w_wr_en),
		.o_wr_addr     (w_wr_addr),
		.o_wr_pixel    (w_wr_pixel),
		.o_wr_bank     (w_wr_bank),
		.o_line_ready  (w_line_ready),
		.o_line_num    (w_line_num)
	);

	line_store u_store
	(
		.i_clk_100_bus (i_clk_100_bus),
		.i_wr_en       (w_wr_en),
		.i_wr_bank     (w_wr_bank),
		.i_wr_addr     (w_wr_addr),
		.i_wr_pixel    (w_wr_pixel),
		.i_rd_bank     (w_rd_bank),
		.i_rd_addr     (w_rd_addr),
		.o_rd_pixel    (w_rd_pixel)
	);

	////////////////////////////////////////////////////////////////////////////
	// Bus side
	////////////////////////////////////////////////////////////////////////////

	burst_writer #(
		.BURST_LEN       (BURST_LEN),
		.PIXELS_PER_LINE (PIXELS_PER_LINE),
		.RAM_BASE_ADDR   (RAM_BASE_ADDR),
		.BYTES_PER_LINE  (BYTES_PER_LINE)
	) u_writer (
		.i_clk_100_bus   (i_clk_100_bus),
		.i_sys_rst       (i_sys_rst),
		.i_mem_init_done (i_mem_init_done),
		.i_line_ready    (w_line_ready),
		.i_line_num      (w_line_num),
		.i_bus_addr_ack  (i_bus_addr_ack),
		.i_bus_wr_comp   (i_bus_wr_comp),
		.o_bus_request   (o_bus_request),
		.o_bus_addr      (o_bus_addr),
		.o_bus_wr_burst  (o_bus_wr_burst),
		.o_line_start    (w_line_start),
		.o_beat          (w_beat),
		.o_line_done     (w_line_done)
	);

	word_formatter #(
		.PIXEL_OFFSET (PIXEL_OFFSET)
	) u_formatter (
		.i_clk_100_bus  (i_clk_100_bus),
		.i_sys_rst      (i_sys_rst),
		.i_wr_bank      (w_wr_bank),
		.i_line_start   (w_line_start),
		.i_beat         (w_beat),
		.i_rd_pixel     (w_rd_pixel),
		.o_rd_bank      (w_rd_bank),
		.o_rd_addr      (w_rd_addr),
		.o_bus_wr_data  (o_bus_wr_data),
		.o_bus_wr_valid (o_bus_wr_valid)
	);

endmodule

/* word_formatter.sv */
/*
 * Output side. Reads the finished bank one pixel per beat and packs
 * each pixel into a bus word, marked valid two cycles after its beat.
 */
module word_formatter
	import video_ram_pkg::*;
#(
	parameter int PIXEL_OFFSET = 10	// First pixel of each line sent out
)
(
	input  logic       i_clk_100_bus,
	input  logic       i_sys_rst,
	input  logic       i_wr_bank,	// Bank the capture side is filling
	input  logic       i_line_start,
	input  logic       i_beat,
	input  pixel_t     i_rd_pixel,
	output logic       o_rd_bank,
	output line_addr_t o_rd_addr,
	output bus_word_t  o_bus_wr_data,
	output logic       o_bus_wr_valid
);

	line_addr_t r_rd_ptr;
	logic       r_beat_d1;	// Beat while memory read is in flight

	assign o_rd_bank = ~i_wr_bank;	// Read the other bank
	assign o_rd_addr = r_rd_ptr;

	// Read pointer and valid pipeline
	always_ff @(posedge i_clk_100_bus or posedge i_sys_rst)
	begin
		if (i_sys_rst)
		begin
			r_rd_ptr       <= '0;
			r_beat_d1      <= 1'b0;
			o_bus_wr_valid <= 1'b0;
		end
		else
		begin
			if (i_line_start)
				r_rd_ptr <= line_addr_t'(PIXEL_OFFSET);	// Skip the left edge
			else if (i_beat)
				r_rd_ptr <= r_rd_ptr + 1'b1;
			r_beat_d1      <= i_beat;
			o_bus_wr_valid <= r_beat_d1;	// Lines up with packed word
		end
	end

	// 6 bits per colour, each left aligned in its own byte
	always_ff @(posedge i_clk_100_bus)
	begin
		o_bus_wr_data <= {8'h00,
			i_rd_pixel[23:18], 2'b00,	// Red
			i_rd_pixel[15:10], 2'b00,	// Green
			i_rd_pixel[7:2],   2'b00};	// Blue
	end

endmodule

/* burst_writer.sv */
/*
 * Memory write FSM. Walks a ready line out as fixed bursts on the bus,
 * stepping the address and telling the formatter when to fetch each beat.
 */
module burst_writer
	import video_ram_pkg::*;
#(
	parameter int        BURST_LEN       = 16,	// Beats per burst
	parameter int        PIXELS_PER_LINE = 720,
	parameter bus_addr_t RAM_BASE_ADDR   = '0,
	parameter int        BYTES_PER_LINE  = 4096	// Line stride in memory
)
(
	input  logic      i_clk_100_bus,
	input  logic      i_sys_rst,
	input  logic      i_mem_init_done,
	input  logic      i_line_ready,
	input  line_num_t i_line_num,
	input  logic      i_bus_addr_ack,
	input  logic      i_bus_wr_comp,
	output logic      o_bus_request,
	output bus_addr_t o_bus_addr,
	output logic      o_bus_wr_burst,
	output logic      o_line_start,	// Reload formatter read pointer
	output logic      o_beat,	// Fetch one word for the bus
	output logic      o_line_done
);

	localparam int BURSTS_PER_LINE = PIXELS_PER_LINE / BURST_LEN;
	localparam int BURST_CNT_W     = $clog2(BURSTS_PER_LINE + 1);
	localparam int BEAT_CNT_W      = $clog2(BURST_LEN + 1);

	localparam logic [BURST_CNT_W-1:0] BURSTS_LAST = BURST_CNT_W'(BURSTS_PER_LINE);
	localparam logic [BEAT_CNT_W-1:0]  BEATS_MAX   = BEAT_CNT_W'(BURST_LEN);
	localparam bus_addr_t LINE_STRIDE = bus_addr_t'(BYTES_PER_LINE);
	localparam bus_addr_t BURST_STEP  = bus_addr_t'(BURST_LEN * BUS_BYTES_PER_WORD);

	writer_state_t r_state;
	writer_state_t c_next;
	logic [BURST_CNT_W-1:0] r_burst_cnt;	// Bursts issued this line
	logic [BEAT_CNT_W-1:0]  r_beat_cnt;	// Beats issued this burst

	////////////////////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		c_next = r_state;
		case (r_state)
			ST_INIT:
				if (i_mem_init_done)
					c_next = ST_START_LINE;
			ST_START_LINE:
				if (i_line_ready)
					c_next = ST_REQUEST;
			ST_REQUEST:
				if (i_bus_addr_ack)
					c_next = ST_WRITE;
			ST_WRITE:
				if (i_bus_wr_comp)
					c_next = ST_COMPLETE;
			ST_COMPLETE:
				c_next = (r_burst_cnt == BURSTS_LAST) ? ST_START_LINE : ST_REQUEST;
			default:
				c_next = ST_INIT;
		endcase
	end

	always_ff @(posedge i_clk_100_bus or posedge i_sys_rst)
	begin
		if (i_sys_rst)
			r_state <= ST_INIT;
		else
			r_state <= c_next;
	end

	// Burst and beat counters
	always_ff @(posedge i_clk_100_bus or posedge i_sys_rst)
	begin
		if (i_sys_rst)
		begin
			r_burst_cnt <= '0;
			r_beat_cnt  <= '0;
		end
		else
		begin
			if (r_state == ST_START_LINE)
				r_burst_cnt <= '0;
			else if (r_state == ST_REQUEST && i_bus_addr_ack)
				r_burst_cnt <= r_burst_cnt + 1'b1;	// Count on grant
			if (r_state == ST_REQUEST)
				r_beat_cnt <= '0;
			else if (o_beat)
				r_beat_cnt <= r_beat_cnt + 1'b1;
		end
	end

	// Line address, then burst steps
	always_ff @(posedge i_clk_100_bus)
	begin
		if (r_state == ST_START_LINE)
			o_bus_addr <= RAM_BASE_ADDR + bus_addr_t'(i_line_num) * LINE_STRIDE;
		else if (r_state == ST_COMPLETE)
			o_bus_addr <= o_bus_addr + BURST_STEP;
	end

	////////////////////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////////////////////

	assign o_bus_request  = (r_state == ST_REQUEST);
	assign o_bus_wr_burst = (r_state == ST_REQUEST) || (r_state == ST_WRITE && !i_bus_wr_comp);
	assign o_beat         = (r_state == ST_WRITE) && (r_beat_cnt < BEATS_MAX);
	assign o_line_start   = (r_state == ST_START_LINE) && i_line_ready;
	assign o_line_done    = (r_state == ST_COMPLETE) && (r_burst_cnt == BURSTS_LAST);

	// Slave completes only once every beat of the burst has been fetched
	a_full_burst : assert property (@(posedge i_clk_100_bus) disable iff (i_sys_rst)
		(r_state == ST_WRITE && i_bus_wr_comp) |-> (r_beat_cnt == BEATS_MAX));

	// Request only while the memory controller reports init done
	a_req_after_init : assert property (@(posedge i_clk_100_bus) disable iff (i_sys_rst)
		o_bus_request |-> i_mem_init_done);

endmodule

/* line_store.sv */
/*
 * Two-bank line memory. One bank is written while the other is read back
 * through a registered port, so read data follows the address by one cycle.
 */
module line_store
	import video_ram_pkg::*;
(
	input  logic       i_clk_100_bus,
	input  logic       i_wr_en,
	input  logic       i_wr_bank,
	input  line_addr_t i_wr_addr,
	input  pixel_t     i_wr_pixel,
	input  logic       i_rd_bank,	// Always the bank not being written
	input  line_addr_t i_rd_addr,
	output pixel_t     o_rd_pixel
);

	////////////////////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////////////////////

	// Bank index first, then pixel slot
	pixel_t mem [2][LINE_DEPTH];

	// Write side
	always_ff @(posedge i_clk_100_bus)
	begin
		if (i_wr_en)
			mem[i_wr_bank][i_wr_addr] <= i_wr_pixel;
	end

	// Read side, one cycle latency
	always_ff @(posedge i_clk_100_bus)
	begin
		o_rd_pixel <= mem[i_rd_bank][i_rd_addr];
	end

endmodule

/* line_capture.sv */
/*
 * Input side of the line capture. Stores strobed pixels into the active
 * line bank, swaps banks on each new line and flags the finished line.
 */
module line_capture
	import video_ram_pkg::*;
(
	input  logic       i_clk_100_bus,
	input  logic       i_sys_rst,
	input  logic       i_pix_valid,	// Pixel strobe from the source
	input  pixel_t     i_pixel,
	input  logic       i_new_line,	// Start of a new line, one cycle
	input  line_num_t  i_line_num,	// Valid with i_new_line
	input  logic       i_line_done,	// Writer has flushed the ready line
	output logic       o_wr_en,
	output line_addr_t o_wr_addr,
	output pixel_t     o_wr_pixel,
	output logic       o_wr_bank,	// Bank being filled
	output logic       o_line_ready,
	output line_num_t  o_line_num
);

	line_addr_t r_pix_cnt;	// Next free slot in the current line

	// Write port, counter, bank and ready flag
	always_ff @(posedge i_clk_100_bus or posedge i_sys_rst)
	begin
		if (i_sys_rst)
		begin
			r_pix_cnt    <= '0;
			o_wr_en      <= 1'b0;
			o_wr_addr    <= '0;
			o_wr_bank    <= 1'b0;	// Fill bank 0 first
			o_line_ready <= 1'b0;
		end
		else
		begin
			o_wr_en <= i_pix_valid;
			if (i_new_line)
			begin
				// Pixel on the same cycle lands at slot 0 of the new bank
				o_wr_addr    <= '0;
				r_pix_cnt    <= i_pix_valid ? line_addr_t'(1) : '0;
				o_wr_bank    <= ~o_wr_bank;
				o_line_ready <= 1'b1;	// Previous bank now holds a full line
			end
			else
			begin
				if (i_pix_valid)
				begin
					o_wr_addr <= r_pix_cnt;
					r_pix_cnt <= r_pix_cnt + 1'b1;
				end
				if (i_line_done)
					o_line_ready <= 1'b0;
			end
		end
	end

	// Pixel data and line number
	always_ff @(posedge i_clk_100_bus)
	begin
		o_wr_pixel <= i_pixel;
		if (i_new_line)
			o_line_num <= i_line_num;	// Number of the line just finished
	end

	// Source must not send more pixels than one bank holds
	a_no_addr_wrap : assert property (@(posedge i_clk_100_bus) disable iff (i_sys_rst)
		(i_pix_valid && !i_new_line) |-> (r_pix_cnt != '1));

endmodule

/* video_ram_pkg.sv */
/*
 * Shared widths, pixel and bus word types, and the writer FSM encoding.
 * Modules of the video capture path pull these in with a wildcard import.
 */
package video_ram_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////

	localparam int PIXEL_W            = 24;	// R, G, B bytes
	localparam int BUS_DATA_W         = 32;	// One bus data word
	localparam int BUS_ADDR_W         = 32;	// Byte address on the bus
	localparam int LINE_ADDR_W        = 11;	// Index into one line buffer
	localparam int LINE_NUM_W         = 10;	// Enough for 480 active lines and more
	localparam int LINE_DEPTH         = 2 ** LINE_ADDR_W;	// Pixels per buffer bank

	// Bytes covered by one data beat, used to step the burst address
	localparam int BUS_BYTES_PER_WORD = 4;

	////////////////////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////////////////////

	// Red in [23:16], green in [15:8], blue in [7:0]
	typedef logic [PIXEL_W-1:0]     pixel_t;
	typedef logic [BUS_DATA_W-1:0]  bus_word_t;
	typedef logic [BUS_ADDR_W-1:0]  bus_addr_t;
	typedef logic [LINE_ADDR_W-1:0] line_addr_t;
	typedef logic [LINE_NUM_W-1:0]  line_num_t;

	// Memory write FSM
	typedef enum logic [2:0]
	{
		ST_INIT       = 3'd0,	// Wait for memory controller init
		ST_START_LINE = 3'd1,	// Wait for a full line, load line address
		ST_REQUEST    = 3'd2,	// Bus request held until address ack
		ST_WRITE      = 3'd3,	// Beats out, then wait for write complete
		ST_COMPLETE   = 3'd4	// Step address, next burst or line done
	} writer_state_t;

endpackage
